// ==== matmul_top.f ====
verilog/matmul_pkg.sv
verilog/mac_pe.sv
verilog/systolic_array.sv
verilog/skew_feeder.sv
verilog/matmul_ctrl.sv
verilog/matmul_top.sv
tb/matmul_ctrl_sva.sv
tb/tb_matmul_top.sv

// ==== Makefile ====
# Verilator build and run for the systolic matrix multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_matmul_top
FILELIST  ?= matmul_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_matmul_top.sv ====
`timescale 1ns/10ps

module tb_matmul_top;
    localparam int n            = matmul_pkg::DEFAULT_MATRIX_SIZE;
    localparam int dw           = matmul_pkg::DEFAULT_DATA_WIDTH;
    localparam int acc_w        = matmul_pkg::acc_width(dw, n);
    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int random_runs  = 40;
    localparam int total_runs   = random_runs + 4;
    localparam int run_margin   = 16;
    localparam int done_bound   = 3 * n + 1;
    localparam int hold_cycles  = 8;
    localparam int watchdog_cycles = total_runs * (done_bound + run_margin) + reset_cycles;

    localparam logic signed [dw-1:0] min_val = {1'b1, {(dw-1){1'b0}}};
    localparam logic signed [dw-1:0] max_val = {1'b0, {(dw-1){1'b1}}};

    logic                    clk;
    logic                    reset;
    logic                    start;
    logic                    done;
    logic signed [dw-1:0]    a_matrix [0:n*n-1];
    logic signed [dw-1:0]    b_matrix [0:n*n-1];
    logic signed [acc_w-1:0] c_matrix [0:n*n-1];
    logic signed [acc_w-1:0] c_expected [0:n*n-1];

    int error_count;
    int check_count;

    matmul_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .a_matrix (a_matrix),
        .b_matrix (b_matrix),
        .done     (done),
        .c_matrix (c_matrix)
    );

    initial begin
        clk = 1'b0;
    end

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    // Reference product, plain triple loop at accumulator width
    task automatic compute_model();
        logic signed [acc_w-1:0] sum;
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < n; j++) begin
                sum = '0;
                for (int k = 0; k < n; k++) begin
                    sum = sum + a_matrix[i*n + k] * b_matrix[k*n + j];
                end
                c_expected[i*n + j] = sum;
            end
        end
    endtask

    task automatic fill_random();
        for (int idx = 0; idx < n * n; idx++) begin
            a_matrix[idx] = dw'($urandom());
            b_matrix[idx] = dw'($urandom());
        end
    endtask

    task automatic fill_const(input logic signed [dw-1:0] value);
        for (int idx = 0; idx < n * n; idx++) begin
            a_matrix[idx] = value;
            b_matrix[idx] = value;
        end
    endtask

    // Constant fill gives n * value * value in every element, at 64 bits
    task automatic check_exact(input logic signed [dw-1:0] value);
        longint exact;
        exact = n * longint'(value) * longint'(value);
        for (int idx = 0; idx < n * n; idx++) begin
            check_count++;
            assert (longint'(c_matrix[idx]) == exact) else begin
                error_count++;
                $display("FAIL c_matrix[%0d] expected %h actual %h (exact sum)",
                         idx, exact, c_matrix[idx]);
            end
        end
    endtask

    // Zero every A row but one, so only that row of C can be nonzero
    task automatic keep_a_row(input int row);
        for (int idx = 0; idx < n * n; idx++) begin
            if (idx / n != row) begin
                a_matrix[idx] = '0;
            end
        end
    endtask

    task automatic check_result(input string label);
        for (int idx = 0; idx < n * n; idx++) begin
            check_count++;
            assert (c_matrix[idx] === c_expected[idx]) else begin
                error_count++;
                $display("FAIL c_matrix[%0d] expected %h actual %h (%s)",
                         idx, c_expected[idx], c_matrix[idx], label);
            end
        end
    endtask

    task automatic wait_for_done(output bit arrived);
        arrived = 1'b0;
        for (int c = 0; c < done_bound && !arrived; c++) begin
            @(negedge clk);
            arrived = done;
        end
        check_count++;
        assert (arrived) else begin
            error_count++;
            $display("ERROR: done never arrived within %0d cycles of start", done_bound);
        end
    endtask

    // Called on a falling edge with the operands already set
    task automatic run_product(input string label);
        bit arrived;
        compute_model();
        start = 1'b1;
        wait_for_done(arrived);
        if (arrived) begin
            check_result(label);
        end
    endtask

    task automatic hold_after_done(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_count++;
            assert (done === 1'b1) else begin
                error_count++;
                $display("FAIL done expected %h actual %h", 1'b1, done);
            end
            check_result("start held");
        end
    endtask

    task automatic release_start();
        bit fell;
        start = 1'b0;
        fell = 1'b0;
        for (int c = 0; c < 2 && !fell; c++) begin
            @(negedge clk);
            fell = !done;
        end
        check_count++;
        assert (fell) else begin
            error_count++;
            $display("ERROR: done stayed high for more than two cycles after start dropped");
        end
        @(negedge clk);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        reset = 1'b1;
        start = 1'b0;
        fill_const('0);
        void'($urandom(32'hd615_4bc1));

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Idle state straight out of reset
        check_count++;
        assert (done === 1'b0) else begin
            error_count++;
            $display("FAIL done expected %h actual %h", 1'b0, done);
        end
        compute_model();
        check_result("after reset");

        // Extremes must sum without overflow
        fill_const(min_val);
        run_product("all most negative");
        check_exact(min_val);
        release_start();
        fill_const(max_val);
        run_product("all most positive");
        check_exact(max_val);
        release_start();

        for (int r = 0; r < random_runs; r++) begin
            fill_random();
            run_product("random");
            if (r == 0) begin
                hold_after_done(hold_cycles);
            end
            release_start();
        end

        // Back to back, first product lives in row 0 and the second in the last row
        fill_random();
        keep_a_row(0);
        run_product("first of pair");
        release_start();
        fill_random();
        keep_a_row(n - 1);
        run_product("second of pair");
        release_start();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb/matmul_ctrl_sva.sv ====
`timescale 1ns/10ps

module matmul_ctrl_sva #(
    parameter int matrix_size = matmul_pkg::DEFAULT_MATRIX_SIZE
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    start,
    input logic                    clear_acc,
    input logic                    feed,
    input logic                    done,
    input matmul_pkg::ctrl_state_e state
);
    localparam int feed_cycles = 2 * matrix_size - 1;

    // Length of the current run of feed cycles
    int feed_len;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            feed_len <= 0;
        end else if (feed) begin
            feed_len <= feed_len + 1;
        end else begin
            feed_len <= 0;
        end
    end

    done_only_in_done: assert property (@(posedge clk) disable iff (reset)
        done |-> state == matmul_pkg::DONE)
        else $error("done is high outside the DONE state");

    clear_after_start: assert property (@(posedge clk) disable iff (reset)
        clear_acc |-> ($past(state) == matmul_pkg::IDLE) && $past(start))
        else $error("clear_acc did not follow IDLE with start high");

    clear_single_cycle: assert property (@(posedge clk) disable iff (reset)
        clear_acc |=> !clear_acc)
        else $error("clear_acc stayed high for more than one cycle");

    feed_not_too_long: assert property (@(posedge clk) disable iff (reset)
        feed |-> feed_len < feed_cycles)
        else $error("feed stayed high past the last wavefront step");

    // A finished feed phase must have covered every step
    feed_full_length: assert property (@(posedge clk) disable iff (reset)
        $fell(feed) |-> feed_len == feed_cycles)
        else $error("feed phase ended early");

endmodule

bind matmul_ctrl matmul_ctrl_sva #(
    .matrix_size (matrix_size)
) u_ctrl_sva (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .clear_acc (clear_acc),
    .feed      (feed),
    .done      (done),
    .state     (state)
);

// ==== verilog/matmul_top.sv ====
`timescale 1ns/10ps

module matmul_top #(
    parameter int matrix_size = matmul_pkg::DEFAULT_MATRIX_SIZE,
    parameter int data_width  = matmul_pkg::DEFAULT_DATA_WIDTH,
    localparam int acc_w      = matmul_pkg::acc_width(data_width, matrix_size)
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic signed [data_width-1:0] a_matrix [0:matrix_size*matrix_size-1],
    input  logic signed [data_width-1:0] b_matrix [0:matrix_size*matrix_size-1],
    output logic                         done,
    output logic signed [acc_w-1:0]      c_matrix [0:matrix_size*matrix_size-1]
);
    localparam int step_width = $clog2(2 * matrix_size);

    logic                         clear_acc;
    logic                         feed;
    logic [step_width-1:0]        step;
    logic signed [data_width-1:0] a_edge [0:matrix_size-1];
    logic signed [data_width-1:0] b_edge [0:matrix_size-1];

    matmul_ctrl #(
        .matrix_size (matrix_size)
    ) u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .clear_acc (clear_acc),
        .feed      (feed),
        .step      (step),
        .done      (done)
    );

    // Skewed wavefronts into the west and north edges
    skew_feeder #(
        .matrix_size (matrix_size),
        .data_width  (data_width)
    ) u_feeder (
        .clk      (clk),
        .reset    (reset),
        .feed     (feed),
        .step     (step),
        .a_matrix (a_matrix),
        .b_matrix (b_matrix),
        .a_edge   (a_edge),
        .b_edge   (b_edge)
    );

    systolic_array #(
        .matrix_size (matrix_size),
        .data_width  (data_width)
    ) u_array (
        .clk       (clk),
        .reset     (reset),
        .clear_acc (clear_acc),
        .a_edge    (a_edge),
        .b_edge    (b_edge),
        .c_matrix  (c_matrix)
    );

endmodule

// ==== verilog/matmul_ctrl.sv ====
`timescale 1ns/10ps

module matmul_ctrl #(
    parameter int matrix_size = matmul_pkg::DEFAULT_MATRIX_SIZE,
    localparam int step_width = $clog2(2 * matrix_size)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic                  clear_acc,
    output logic                  feed,
    output logic [step_width-1:0] step,
    output logic                  done
);
    // Last feed step and last drain cycle
    localparam int last_step  = 2 * matrix_size - 2;
    localparam int last_drain = matrix_size - 1;

    matmul_pkg::ctrl_state_e state;
    matmul_pkg::ctrl_state_e state_next;

    // Shared by FEED (step index) and DRAIN (cycle count)
    logic [step_width-1:0] count;
    logic [step_width-1:0] count_next;

    always_comb begin
        state_next = state;
        count_next = count;
        case (state)
            matmul_pkg::IDLE: begin
                count_next = '0;
                if (start) begin
                    state_next = matmul_pkg::CLEAR;
                end
            end
            matmul_pkg::CLEAR: begin
                count_next = '0;
                state_next = matmul_pkg::FEED;
            end
            matmul_pkg::FEED: begin
                if (count == step_width'(last_step)) begin
                    count_next = '0;
                    state_next = matmul_pkg::DRAIN;
                end else begin
                    count_next = count + 1'b1;
                end
            end
            matmul_pkg::DRAIN: begin
                // Wait for the last operands to cross the grid
                if (count == step_width'(last_drain)) begin
                    count_next = '0;
                    state_next = matmul_pkg::DONE;
                end else begin
                    count_next = count + 1'b1;
                end
            end
            matmul_pkg::DONE: begin
                count_next = '0;
                if (!start) begin
                    state_next = matmul_pkg::IDLE;
                end
            end
            default: begin
                count_next = '0;
                state_next = matmul_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= matmul_pkg::IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            // Rises on entry to DONE, falls on the way back to IDLE
            done  <= (state_next == matmul_pkg::DONE);
        end
    end

    assign clear_acc = (state == matmul_pkg::CLEAR);
    assign feed      = (state == matmul_pkg::FEED);
    assign step      = count;

endmodule

// ==== verilog/skew_feeder.sv ====
`timescale 1ns/10ps

module skew_feeder #(
    parameter int matrix_size = matmul_pkg::DEFAULT_MATRIX_SIZE,
    parameter int data_width  = matmul_pkg::DEFAULT_DATA_WIDTH,
    localparam int step_width = $clog2(2 * matrix_size)
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         feed,
    input  logic [step_width-1:0]        step,
    input  logic signed [data_width-1:0] a_matrix [0:matrix_size*matrix_size-1],
    input  logic signed [data_width-1:0] b_matrix [0:matrix_size*matrix_size-1],
    output logic signed [data_width-1:0] a_edge [0:matrix_size-1],
    output logic signed [data_width-1:0] b_edge [0:matrix_size-1]
);
    logic signed [data_width-1:0] a_pick [0:matrix_size-1];
    logic signed [data_width-1:0] b_pick [0:matrix_size-1];

    // Anti-diagonal select: row i gets A[i][t-i], column j gets B[t-j][j]
    always_comb begin
        int t;
        int k;
        t = int'(step);
        for (int i = 0; i < matrix_size; i++) begin
            k = t - i;
            a_pick[i] = '0;
            b_pick[i] = '0;
            if (k >= 0 && k < matrix_size) begin
                a_pick[i] = a_matrix[i*matrix_size + k];
                b_pick[i] = b_matrix[k*matrix_size + i];
            end
        end
    end

    // Zero edges outside FEED keep the accumulators still
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < matrix_size; i++) begin
                a_edge[i] <= '0;
                b_edge[i] <= '0;
            end
        end else begin
            for (int i = 0; i < matrix_size; i++) begin
                a_edge[i] <= feed ? a_pick[i] : '0;
                b_edge[i] <= feed ? b_pick[i] : '0;
            end
        end
    end

endmodule

// ==== verilog/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array #(
    parameter int matrix_size = matmul_pkg::DEFAULT_MATRIX_SIZE,
    parameter int data_width  = matmul_pkg::DEFAULT_DATA_WIDTH,
    localparam int acc_w      = matmul_pkg::acc_width(data_width, matrix_size)
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clear_acc,
    input  logic signed [data_width-1:0] a_edge [0:matrix_size-1],
    input  logic signed [data_width-1:0] b_edge [0:matrix_size-1],
    output logic signed [acc_w-1:0]      c_matrix [0:matrix_size*matrix_size-1]
);
    // a runs left to right along a row, b runs top to bottom down a column
    logic signed [data_width-1:0] a_link [0:matrix_size-1][0:matrix_size];
    logic signed [data_width-1:0] b_link [0:matrix_size][0:matrix_size-1];

    for (genvar i = 0; i < matrix_size; i++) begin : g_edge
        assign a_link[i][0] = a_edge[i];
        assign b_link[0][i] = b_edge[i];
    end

    for (genvar i = 0; i < matrix_size; i++) begin : g_row
        for (genvar j = 0; j < matrix_size; j++) begin : g_col
            // PE(i,j) owns C[i][j]
            mac_pe #(
                .data_width  (data_width),
                .acc_width_p (acc_w)
            ) u_pe (
                .clk       (clk),
                .reset     (reset),
                .clear_acc (clear_acc),
                .a_in      (a_link[i][j]),
                .b_in      (b_link[i][j]),
                .a_out     (a_link[i][j+1]),
                .b_out     (b_link[i+1][j]),
                .acc       (c_matrix[i*matrix_size + j])
            );
        end
    end

endmodule

// ==== verilog/mac_pe.sv ====
`timescale 1ns/10ps

module mac_pe #(
    parameter int data_width  = matmul_pkg::DEFAULT_DATA_WIDTH,
    parameter int acc_width_p = 2 * matmul_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clear_acc,
    input  logic signed [data_width-1:0]  a_in,
    input  logic signed [data_width-1:0]  b_in,
    output logic signed [data_width-1:0]  a_out,
    output logic signed [data_width-1:0]  b_out,
    output logic signed [acc_width_p-1:0] acc
);
    logic signed [2*data_width-1:0] product;

    assign product = a_in * b_in;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            // Operands move on one PE per cycle
            a_out <= a_in;
            b_out <= b_in;
            if (clear_acc) begin
                acc <= '0;
            end else begin
                acc <= acc + product;
            end
        end
    end

endmodule

// ==== verilog/matmul_pkg.sv ====
package matmul_pkg;

    // Size defaults picked up by the top level
    parameter int DEFAULT_MATRIX_SIZE = 4;
    parameter int DEFAULT_DATA_WIDTH  = 8;

    // Full product width plus enough guard bits for N partial sums
    function automatic int acc_width(
        input int data_width,
        input int matrix_size
    );
        int guard_bits;
        guard_bits = $clog2(matrix_size);
        return 2 * data_width + guard_bits;
    endfunction

    // Run control states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        CLEAR = 3'd1,
        FEED  = 3'd2,
        DRAIN = 3'd3,
        DONE  = 3'd4
    } ctrl_state_e;

endpackage
